// ==== testbench/cpuPatterns.txt ====
# P <byte address> <instruction word>
# E <pc> <regWe> <regAddr> <regData> <memWe> <memAddr> <memData>
P 00 00500093
P 04 FFD00113
P 08 002081B3
P 0C 40208233
P 10 0020F2B3
P 14 0020E333
P 18 0020C3B3
P 1C 00112433
P 20 0020A4B3
P 24 01400513
P 28 00A095B3
P 2C 00A15633
P 30 0F017693
P 34 1000E713
P 38 FFF0C793
P 3C FFE12813
P 40 00708013
P 44 001008B3
P 48 00102423
P 4C 00202623
P 50 00802903
P 54 00C02983
P 58 01108463
P 5C 06300A13
P 60 00109463
P 64 00208463
P 68 00300A93
P 6C FFFA8A93
P 70 FE0A9EE3
P 74 0000007F
E 00 1 01 00000005 0 0 0
E 04 1 02 FFFFFFFD 0 0 0
E 08 1 03 00000002 0 0 0
E 0C 1 04 00000008 0 0 0
E 10 1 05 00000005 0 0 0
E 14 1 06 FFFFFFFD 0 0 0
E 18 1 07 FFFFFFF8 0 0 0
E 1C 1 08 00000001 0 0 0
E 20 1 09 00000000 0 0 0
E 24 1 0A 00000014 0 0 0
E 28 1 0B 00500000 0 0 0
E 2C 1 0C 00000FFF 0 0 0
E 30 1 0D 000000F0 0 0 0
E 34 1 0E 00000105 0 0 0
E 38 1 0F FFFFFFFA 0 0 0
E 3C 1 10 00000001 0 0 0
# addi x0 still shows a write, the next add reads x0 as zero
E 40 1 00 0000000C 0 0 0
E 44 1 11 00000005 0 0 0
E 48 0 00 0 1 00000008 00000005
E 4C 0 00 0 1 0000000C FFFFFFFD
E 50 1 12 00000005 0 0 0
E 54 1 13 FFFFFFFD 0 0 0
# beq taken skips 5C, then two branches not taken
E 58 0 00 0 0 0 0
E 60 0 00 0 0 0 0
E 64 0 00 0 0 0 0
# Counted loop with a backward bne
E 68 1 15 00000003 0 0 0
E 6C 1 15 00000002 0 0 0
E 70 0 00 0 0 0 0
E 6C 1 15 00000001 0 0 0
E 70 0 00 0 0 0 0
E 6C 1 15 00000000 0 0 0
E 70 0 00 0 0 0 0
# Unknown opcode
E 74 0 00 0 0 0 0

// ==== project.f ====
design/cpuPkg.sv
design/instMem.sv
design/regFile.sv
design/decoder.sv
design/alu.sv
design/dataMem.sv
design/singleCpu.sv
testbench/tbClock.sv
testbench/tbSingleCpu.sv

// ==== Bender.yml ====
package:
  name: singleCpu

sources:
  - files:
      - design/cpuPkg.sv
      - design/instMem.sv
      - design/regFile.sv
      - design/decoder.sv
      - design/alu.sv
      - design/dataMem.sv
      - design/singleCpu.sv
  - target: test
    files:
      - testbench/tbClock.sv
      - testbench/tbSingleCpu.sv

// ==== testbench/tbSingleCpu.sv ====
`timescale 1ns/1ps

module tbSingleCpu
    import cpuPkg::*;
();

    logic    CLK, arstN;
    logic    progWe, run;
    word_t   progAddr, progData;
    word_t   pc, inst, regData, memAddr, memData;
    logic    regWe, memWe;
    regIdx_t regAddr;

    // Program image and expected retire trace
    word_t   loadAddrQ[$];
    word_t   loadDataQ[$];
    word_t   expPcQ[$];
    logic    expRegWeQ[$];
    regIdx_t expRegAddrQ[$];
    word_t   expRegDataQ[$];
    logic    expMemWeQ[$];
    word_t   expMemAddrQ[$];
    word_t   expMemDataQ[$];

    int errors = 0;
    int cycles = 0;
    int cycleLimit = 0; // Zero until the trace is parsed

    tbClock u_clk (.CLK(CLK), .arstN(arstN));

    singleCpu #(.instAddrBits(6), .dataAddrBits(6)) u_dut (
        .CLK(CLK), .arstN(arstN), .progWe(progWe), .progAddr(progAddr),
        .progData(progData), .run(run), .pc(pc), .inst(inst), .regWe(regWe),
        .regAddr(regAddr), .regData(regData), .memWe(memWe), .memAddr(memAddr),
        .memData(memData)
    );

    task automatic checkWord(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            errors++;
            $display("Mismatch %s: got %h expected %h (pc %h)", name, got, exp, pc);
        end
    endtask

    task automatic checkIdx(input string name, input regIdx_t got, input regIdx_t exp);
        if (got !== exp) begin
            errors++;
            $display("Mismatch %s: got %h expected %h (pc %h)", name, got, exp, pc);
        end
    endtask

    task automatic checkBit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            errors++;
            $display("Mismatch %s: got %h expected %h (pc %h)", name, got, exp, pc);
        end
    endtask

    task automatic readPatterns();
        int fd;
        logic [1023:0] line;
        logic [31:0] f[7];
        fd = $fopen("testbench/cpuPatterns.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("Could not open the pattern file");
            return;
        end
        while (!$feof(fd)) begin
            line = '0;
            void'($fgets(line, fd));
            if ($sscanf(line, "P %h %h", f[0], f[1]) == 2) begin
                loadAddrQ.push_back(f[0]);
                loadDataQ.push_back(f[1]);
            end else if ($sscanf(line, "E %h %h %h %h %h %h %h",
                                 f[0], f[1], f[2], f[3], f[4], f[5], f[6]) == 7) begin
                expPcQ.push_back(f[0]);
                expRegWeQ.push_back(f[1][0]);
                expRegAddrQ.push_back(f[2][4:0]);
                expRegDataQ.push_back(f[3]);
                expMemWeQ.push_back(f[4][0]);
                expMemAddrQ.push_back(f[5]);
                expMemDataQ.push_back(f[6]);
            end // Comment lines match neither form
        end
        $fclose(fd);
    endtask

    // Word loaded at a byte address, zero where nothing was loaded
    function automatic word_t programWord(input word_t addr);
        foreach (loadAddrQ[i]) begin
            if (loadAddrQ[i] == addr) begin
                return loadDataQ[i];
            end
        end
        return '0;
    endfunction

    // Writes are idle and pc parked while run is low
    task automatic checkStalled();
        checkWord("pc", pc, '0);
        checkBit("regWe", regWe, 1'b0);
        checkBit("memWe", memWe, 1'b0);
    endtask

    // One cycle with run low while a store sits at pc
    task automatic stallBeforeStore(input word_t expPc);
        run = 1'b0;
        #10;
        checkWord("pc", pc, expPc);
        checkBit("regWe", regWe, 1'b0);
        checkBit("memWe", memWe, 1'b0);
        @(negedge CLK);
        run = 1'b1;
    endtask

    always @(posedge CLK) begin
        cycles++;
        if (cycleLimit != 0 && cycles >= cycleLimit) begin
            errors++;
            $display("Timeout: run did not finish");
            $display("Errors: %0d", errors);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    initial begin
        progWe   = 1'b0;
        progAddr = '0;
        progData = '0;
        run      = 1'b0;
        readPatterns();
        cycleLimit = 2 * expPcQ.size() + loadAddrQ.size() + 20;
        if (expPcQ.size() == 0) begin
            errors++;
            $display("No expected lines were found in the pattern file");
        end
        wait (arstN === 1'b1);

        // Load phase, run held low
        foreach (loadAddrQ[i]) begin
            @(negedge CLK);
            progWe   = 1'b1;
            progAddr = loadAddrQ[i];
            progData = loadDataQ[i];
            #10 checkStalled();
        end
        @(negedge CLK);
        progWe = 1'b0;
        #10 checkStalled();

        // One expected line per retired instruction
        @(negedge CLK);
        run = 1'b1;
        foreach (expPcQ[i]) begin
            if (expMemWeQ[i]) begin
                stallBeforeStore(expPcQ[i]);
            end
            #10;
            checkWord("pc", pc, expPcQ[i]);
            checkWord("inst", inst, programWord(expPcQ[i]));
            checkBit("regWe", regWe, expRegWeQ[i]);
            if (expRegWeQ[i]) begin
                checkIdx("regAddr", regAddr, expRegAddrQ[i]);
                checkWord("regData", regData, expRegDataQ[i]);
            end
            checkBit("memWe", memWe, expMemWeQ[i]);
            if (expMemWeQ[i]) begin
                checkWord("memAddr", memAddr, expMemAddrQ[i]);
                checkWord("memData", memData, expMemDataQ[i]);
            end
            @(negedge CLK);
        end
        run = 1'b0;

        // Trace ends on a non-branch, so pc sits one word past it
        if (expPcQ.size() != 0) begin
            #10 checkWord("pc", pc, expPcQ[expPcQ.size()-1] + 32'd4);
        end

        $display("Errors: %0d", errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== testbench/tbClock.sv ====
`timescale 1ns/1ps

module tbClock (
    output logic CLK,
    output logic arstN
);

    initial begin
        CLK = 1'b0;
        forever #50 CLK = ~CLK; // 100 ns period
    end

    // Reset held low for four rising edges, released on a falling edge
    initial begin
        arstN = 1'b0;
        repeat (4) @(posedge CLK);
        @(negedge CLK);
        arstN = 1'b1;
    end

endmodule

// ==== design/singleCpu.sv ====
`timescale 1ns/1ps

module singleCpu
    import cpuPkg::*;
#(
    parameter int instAddrBits = 6,
    parameter int dataAddrBits = 6
) (
    input  logic    CLK,
    input  logic    arstN,
    input  logic    progWe,
    input  word_t   progAddr,
    input  word_t   progData,
    input  logic    run,
    output word_t   pc,
    output word_t   inst,
    output logic    regWe,
    output regIdx_t regAddr,
    output word_t   regData,
    output logic    memWe,
    output word_t   memAddr,
    output word_t   memData
);

    regIdx_t rs1, rs2, rd;
    word_t   imm, rd1, rd2, aluB, result, readData, wbData;
    aluOp_t  aluOp;
    logic    aluSrcImm, regWrite, memWrite, memToReg, branch, branchNe, zero;
    logic    branchTaken;
    word_t   pcPlus4, branchTarget, nextPc;

    instMem #(.instAddrBits(instAddrBits)) u_instMem (
        .CLK     (CLK),
        .progWe  (progWe),
        .progAddr(progAddr),
        .progData(progData),
        .pc      (pc),
        .inst    (inst)
    );

    decoder u_decoder (
        .inst     (inst),
        .rs1      (rs1),
        .rs2      (rs2),
        .rd       (rd),
        .imm      (imm),
        .aluOp    (aluOp),
        .aluSrcImm(aluSrcImm),
        .regWrite (regWrite),
        .memWrite (memWrite),
        .memToReg (memToReg),
        .branch   (branch),
        .branchNe (branchNe)
    );

    regFile u_regFile (
        .CLK  (CLK),
        .arstN(arstN),
        .rs1  (rs1),
        .rs2  (rs2),
        .rd   (rd),
        .wdata(wbData),
        .we   (regWe),
        .rd1  (rd1),
        .rd2  (rd2)
    );

    assign aluB = aluSrcImm ? imm : rd2;

    alu u_alu (.a(rd1), .b(aluB), .op(aluOp), .result(result), .zero(zero));

    dataMem #(.dataAddrBits(dataAddrBits)) u_dataMem (
        .CLK  (CLK),
        .addr (result),
        .wdata(rd2),
        .we   (memWe),
        .rdata(readData)
    );

    assign wbData = memToReg ? readData : result;

    // Writes only happen while running
    assign regWe = regWrite & run;
    assign memWe = memWrite & run;

    assign pcPlus4      = pc + 32'd4;
    assign branchTarget = pc + imm;
    assign branchTaken  = branch & (branchNe ? ~zero : zero);
    assign nextPc       = branchTaken ? branchTarget : pcPlus4;

    always_ff @(posedge CLK or negedge arstN) begin
        if (!arstN) begin
            pc <= '0;
        end else if (run) begin
            pc <= nextPc; // run low holds the pc
        end
    end

    // Observation outputs
    assign regAddr = rd;
    assign regData = wbData;
    assign memAddr = result;
    assign memData = rd2;

    // Branch offsets from the decoder must keep fetches on word boundaries
    pcAligned: assert property (@(posedge CLK) disable iff (!arstN) pc[1:0] == 2'b00)
        else $error("singleCpu: misaligned pc %h", pc);

endmodule

// ==== design/dataMem.sv ====
`timescale 1ns/1ps

module dataMem
    import cpuPkg::*;
#(
    parameter int dataAddrBits = 6
) (
    input  logic  CLK,
    input  word_t addr,
    input  word_t wdata,
    input  logic  we,
    output word_t rdata
);

    localparam int dataDepth = 2 ** dataAddrBits;

    word_t mem [dataDepth];

    logic [dataAddrBits-1:0] wordIdx;

    // Byte address down to a word index, upper bits wrap
    assign wordIdx = addr[dataAddrBits+1:2];

    always_ff @(posedge CLK) begin
        if (we) begin
            mem[wordIdx] <= wdata;
        end
    end

    // Read sees the stored word, not the one being written this cycle
    assign rdata = mem[wordIdx];

    storeAligned: assert property (@(posedge CLK) we |-> addr[1:0] == 2'b00)
        else $error("dataMem: unaligned store address %h", addr);

endmodule

// ==== design/alu.sv ====
`timescale 1ns/1ps

module alu
    import cpuPkg::*;
(
    input  word_t  a,
    input  word_t  b,
    input  aluOp_t op,
    output word_t  result,
    output logic   zero
);

    logic [4:0] shamt;

    assign shamt = b[4:0]; // Upper bits of the shift amount are ignored

    always_comb begin
        case (op)
            aluAdd: begin
                result = a + b;
            end
            aluSub: begin
                result = a - b;
            end
            aluAnd: begin
                result = a & b;
            end
            aluOr: begin
                result = a | b;
            end
            aluXor: begin
                result = a ^ b;
            end
            aluSlt: begin
                // Two's complement compare
                result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            end
            aluSll: begin
                result = a << shamt;
            end
            aluSrl: begin
                result = a >> shamt; // Logical, zero fill
            end
            default: begin
                result = '0;
            end
        endcase
    end

    // Branch condition for beq and bne
    assign zero = (result == '0);

endmodule

// ==== design/decoder.sv ====
`timescale 1ns/1ps

module decoder
    import cpuPkg::*;
(
    input  word_t   inst,
    output regIdx_t rs1,
    output regIdx_t rs2,
    output regIdx_t rd,
    output word_t   imm,
    output aluOp_t  aluOp,
    output logic    aluSrcImm,
    output logic    regWrite,
    output logic    memWrite,
    output logic    memToReg,
    output logic    branch,
    output logic    branchNe
);

    opcode_t    opcode;
    immKind_t   immKind;
    logic [2:0] funct3;
    logic       aluInst; // R-type or I-type arithmetic

    assign opcode = opcode_t'(inst[6:0]);
    assign funct3 = inst[14:12];

    // Register fields sit in fixed places for every format
    assign rs1 = inst[19:15];
    assign rs2 = inst[24:20];
    assign rd  = inst[11:7];

    // Main control
    always_comb begin
        aluSrcImm = 1'b0;
        regWrite  = 1'b0;
        memWrite  = 1'b0;
        memToReg  = 1'b0;
        branch    = 1'b0;
        branchNe  = 1'b0;
        aluInst   = 1'b0;
        immKind   = immI;
        case (opcode)
            opReg: begin
                regWrite = 1'b1;
                aluInst  = 1'b1;
            end
            opImm: begin
                regWrite  = 1'b1;
                aluSrcImm = 1'b1;
                aluInst   = 1'b1;
            end
            opLoad: begin
                regWrite  = 1'b1;
                aluSrcImm = 1'b1;
                memToReg  = 1'b1;
            end
            opStore: begin
                memWrite  = 1'b1;
                aluSrcImm = 1'b1;
                immKind   = immS;
            end
            opBranch: begin
                immKind  = immB;
                branch   = (funct3[2:1] == 2'b00); // Only beq and bne
                branchNe = funct3[0];
            end
            default: ; // Unknown opcode falls through as a no-op
        endcase
    end

    // ALU operation from funct3, bit 30 picks sub on R-type only
    always_comb begin
        aluOp = aluAdd; // Address add for lw and sw
        if (opcode == opBranch) begin
            aluOp = aluSub; // Compare by subtraction
        end else if (aluInst) begin
            case (funct3)
                3'b000:  aluOp = (opcode == opReg && inst[30]) ? aluSub : aluAdd;
                3'b001:  aluOp = aluSll;
                3'b010:  aluOp = aluSlt;
                3'b100:  aluOp = aluXor;
                3'b101:  aluOp = aluSrl;
                3'b110:  aluOp = aluOr;
                3'b111:  aluOp = aluAnd;
                default: aluOp = aluAdd;
            endcase
        end
    end

    // Sign-extended immediates
    always_comb begin
        case (immKind)
            immS:    imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
            immB:    imm = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
            default: imm = {{20{inst[31]}}, inst[31:20]};
        endcase
    end

endmodule

// ==== design/regFile.sv ====
`timescale 1ns/1ps

module regFile
    import cpuPkg::*;
(
    input  logic    CLK,
    input  logic    arstN,
    input  regIdx_t rs1,
    input  regIdx_t rs2,
    input  regIdx_t rd,
    input  word_t   wdata,
    input  logic    we,
    output word_t   rd1,
    output word_t   rd2
);

    word_t regs [32];

    // Entry 0 is cleared on reset and never written afterwards
    always_ff @(posedge CLK or negedge arstN) begin
        if (!arstN) begin
            regs <= '{default: '0};
        end else if (we && rd != '0) begin
            regs[rd] <= wdata;
        end
    end

    // Old value seen during a same-cycle write
    assign rd1 = regs[rs1];
    assign rd2 = regs[rs2];

    // A write to x0 in an earlier cycle must not leak into a later read
    x0ReadsZero: assert property (
        @(posedge CLK) disable iff (!arstN)
        (rs1 == '0 |-> rd1 == '0) and (rs2 == '0 |-> rd2 == '0)
    ) else $error("regFile: x0 read back nonzero");

endmodule

// ==== design/instMem.sv ====
`timescale 1ns/1ps

module instMem
    import cpuPkg::*;
#(
    parameter int instAddrBits = 6
) (
    input  logic  CLK,
    input  logic  progWe,
    input  word_t progAddr,
    input  word_t progData,
    input  word_t pc,
    output word_t inst
);

    localparam int instDepth = 2 ** instAddrBits;

    // Unloaded words read as 0 and decode as a no-op
    word_t mem [instDepth] = '{default: '0};

    logic pcInRange;

    // Program load from the testbench, byte address to word index
    always_ff @(posedge CLK) begin
        if (progWe) begin
            mem[progAddr[instAddrBits+1:2]] <= progData;
        end
    end

    assign pcInRange = (pc[31:instAddrBits+2] == '0);
    assign inst      = pcInRange ? mem[pc[instAddrBits+1:2]] : '0; // Past the end fetches a no-op

    progAligned: assert property (@(posedge CLK) progWe |-> progAddr[1:0] == 2'b00)
        else $error("instMem: unaligned program address %h", progAddr);

endmodule

// ==== design/cpuPkg.sv ====
package cpuPkg;

    // Data, address and instruction words share one width
    typedef logic [31:0] word_t;

    typedef logic [4:0] regIdx_t; // x0 .. x31

    // Major opcodes of the supported subset
    typedef enum logic [6:0] {
        opReg    = 7'b0110011, // add sub and or xor slt sll srl
        opImm    = 7'b0010011, // addi andi ori xori slti
        opLoad   = 7'b0000011, // lw
        opStore  = 7'b0100011, // sw
        opBranch = 7'b1100011  // beq bne
    } opcode_t;

    typedef enum logic [3:0] {
        aluAdd = 4'd0,
        aluSub = 4'd1,
        aluAnd = 4'd2,
        aluOr  = 4'd3,
        aluXor = 4'd4,
        aluSlt = 4'd5, // Signed compare
        aluSll = 4'd6,
        aluSrl = 4'd7
    } aluOp_t;

    // Immediate layouts used by the decoder
    typedef enum logic [1:0] {
        immI,
        immS,
        immB // Carries bit 0 as zero
    } immKind_t;

endpackage
